// ==== common/ddl_cfg.svh ====
`ifndef DDL_CFG_SVH
`define DDL_CFG_SVH

// Controller and PHY widths
`define DDL_ROW_BITS 13
`define DDL_BANK_BITS 3
`define DDL_DATA_BITS 32
// One mask bit per data byte
`define DDL_MASK_BITS 4

// Wide enough for the ZQ calibration wait
`define DDL_CNT_BITS 10

// Clock-enable high to the first command
`define DDL_T_XPR 5

// Command to command delays, in controller cycles
`define DDL_T_MRD 4
`define DDL_T_RP 3
`define DDL_T_RCD 3
`define DDL_T_RFC 11

// Column commands in the same direction or straight after ACT
`define DDL_T_CCD 4

// Turnaround between directions
`define DDL_T_RTW 6
`define DDL_T_WTR 14

// Column commands with auto-precharge through A10
`define DDL_T_RDA 8
`define DDL_T_WRA 16

// Long-form ZQ calibration
`define DDL_T_ZQINIT 512

// Write latency less the PHY write latency
`define DDL_WR_LEAD 4

// BL8 takes four controller cycles
`define DDL_BURST_CYCLES 4

`endif

// ==== common/ddl_pkg.sv ====
`default_nettype none

`include "ddl_cfg.svh"

package ddl_pkg;

  // Encoded as the active-low DDR3 {ras, cas, we} pins
  typedef enum logic [2:0] {
    CMD_MRS  = 3'd0,
    CMD_REF  = 3'd1,
    CMD_PRE  = 3'd2,
    CMD_ACT  = 3'd3,
    CMD_WR   = 3'd4,
    CMD_RD   = 3'd5,
    CMD_ZQCL = 3'd6,
    CMD_NOP  = 3'd7
  } ddl_cmd_e;

  // One class of the last issued command for all banks
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACTV,
    ST_READ,
    ST_WRIT,
    ST_PREC,
    ST_REFR,
    ST_MODE,
    ST_ZQCL
  } ddl_state_e;

  typedef struct packed {
    ddl_cmd_e                   cmd;
    logic [`DDL_BANK_BITS-1:0]  bank;
    logic [`DDL_ROW_BITS-1:0]   addr;
  } ddl_req_t;

  typedef struct packed {
    logic                       ras_n;
    logic                       cas_n;
    logic                       we_n;
    logic [`DDL_BANK_BITS-1:0]  bank;
    logic [`DDL_ROW_BITS-1:0]   addr;
  } dfi_cmd_t;

  typedef struct packed {
    logic [`DDL_MASK_BITS-1:0]  mask;
    logic [`DDL_DATA_BITS-1:0]  data;
  } ddl_wdata_t;

  typedef struct packed {
    logic [`DDL_DATA_BITS-1:0]  data;
  } ddl_rdata_t;

  typedef logic [`DDL_CNT_BITS-1:0] ddl_cnt_t;

endpackage

`default_nettype wire

// ==== hw/sequencer/ddl_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddl_cfg.svh"

module ddl_timer (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    load_i,
  input  wire ddl_pkg::ddl_cnt_t delay_i,
  output logic                   ready_o
);

  // Cycles left before the next command may be taken
  ddl_pkg::ddl_cnt_t count_q;

  // The load edge is the first cycle of the delay, so the count
  // starts one short and ready returns D edges after the load
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= ddl_pkg::ddl_cnt_t'(`DDL_T_XPR);
    end else if (load_i) begin
      count_q <= delay_i - 1'b1;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign ready_o = (count_q == '0);

  // A zero delay would wrap to the longest wait
  assert property (@(posedge clock) disable iff (reset)
    load_i |-> (delay_i != '0));

endmodule

`default_nettype wire

// ==== hw/sequencer/ddl_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddl_cfg.svh"

module ddl_sequencer (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 ddr_cke_i,
  input  wire                 ctl_req_i,
  input  wire ddl_pkg::ddl_req_t ctl_cmd_i,
  output logic                ctl_rdy_o,
  output ddl_pkg::dfi_cmd_t   dfi_cmd_o
);

  localparam ddl_pkg::ddl_cnt_t T_MRD    = `DDL_T_MRD;
  localparam ddl_pkg::ddl_cnt_t T_RP     = `DDL_T_RP;
  localparam ddl_pkg::ddl_cnt_t T_RCD    = `DDL_T_RCD;
  localparam ddl_pkg::ddl_cnt_t T_RFC    = `DDL_T_RFC;
  localparam ddl_pkg::ddl_cnt_t T_CCD    = `DDL_T_CCD;
  localparam ddl_pkg::ddl_cnt_t T_RTW    = `DDL_T_RTW;
  localparam ddl_pkg::ddl_cnt_t T_WTR    = `DDL_T_WTR;
  localparam ddl_pkg::ddl_cnt_t T_RDA    = `DDL_T_RDA;
  localparam ddl_pkg::ddl_cnt_t T_WRA    = `DDL_T_WRA;
  localparam ddl_pkg::ddl_cnt_t T_ZQINIT = `DDL_T_ZQINIT;
  // The first live edge after clock-enable rises counts as an accept
  localparam ddl_pkg::ddl_cnt_t T_HOLD   = `DDL_T_XPR + 1;

  ddl_pkg::ddl_state_e        state_q;
  ddl_pkg::ddl_state_e        state_d;
  ddl_pkg::ddl_cmd_e          cmd_q;
  logic [`DDL_BANK_BITS-1:0]  bank_q;
  logic [`DDL_ROW_BITS-1:0]   addr_q;
  ddl_pkg::ddl_cnt_t          delay;
  ddl_pkg::ddl_cnt_t          timer_delay;
  logic                       timer_load;
  logic                       timer_ready;
  logic                       accept;
  logic                       legal;
  logic                       issue;
  logic                       auto_pre;

  assign ctl_rdy_o = timer_ready & ddr_cke_i;
  assign accept    = ctl_req_i & ctl_rdy_o;
  assign auto_pre  = ctl_cmd_i.addr[10];
  assign issue     = accept & legal;

  // Legality, next class and delay for the requested command
  always_comb begin
    legal   = 1'b0;
    state_d = state_q;
    delay   = T_CCD;
    case (ctl_cmd_i.cmd)
      ddl_pkg::CMD_MRS: begin
        legal   = state_q inside {ddl_pkg::ST_IDLE, ddl_pkg::ST_PREC, ddl_pkg::ST_MODE};
        state_d = ddl_pkg::ST_MODE;
        delay   = T_MRD;
      end
      ddl_pkg::CMD_REF: begin
        legal   = state_q inside {ddl_pkg::ST_IDLE, ddl_pkg::ST_PREC, ddl_pkg::ST_REFR,
                                  ddl_pkg::ST_MODE, ddl_pkg::ST_ZQCL};
        state_d = ddl_pkg::ST_REFR;
        delay   = T_RFC;
      end
      ddl_pkg::CMD_PRE: begin
        legal   = 1'b1;
        state_d = ddl_pkg::ST_PREC;
        delay   = T_RP;
      end
      ddl_pkg::CMD_ACT: begin
        legal   = (state_q != ddl_pkg::ST_MODE);
        state_d = ddl_pkg::ST_ACTV;
        delay   = T_RCD;
      end
      ddl_pkg::CMD_WR: begin
        legal = state_q inside {ddl_pkg::ST_ACTV, ddl_pkg::ST_READ, ddl_pkg::ST_WRIT};
        if (auto_pre) begin
          state_d = ddl_pkg::ST_PREC;
          delay   = T_WRA;
        end else begin
          state_d = ddl_pkg::ST_WRIT;
          delay   = (state_q == ddl_pkg::ST_READ) ? T_RTW : T_CCD;
        end
      end
      ddl_pkg::CMD_RD: begin
        legal = state_q inside {ddl_pkg::ST_ACTV, ddl_pkg::ST_READ, ddl_pkg::ST_WRIT};
        if (auto_pre) begin
          state_d = ddl_pkg::ST_PREC;
          delay   = T_RDA;
        end else begin
          state_d = ddl_pkg::ST_READ;
          delay   = (state_q == ddl_pkg::ST_WRIT) ? T_WTR : T_CCD;
        end
      end
      ddl_pkg::CMD_ZQCL: begin
        legal   = state_q inside {ddl_pkg::ST_IDLE, ddl_pkg::ST_MODE};
        state_d = ddl_pkg::ST_ZQCL;
        delay   = T_ZQINIT;
      end
      // NOP is never issued
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // Clock-enable low keeps the timer parked at the init wait
  assign timer_load  = issue | ~ddr_cke_i;
  assign timer_delay = ddr_cke_i ? delay : T_HOLD;

  ddl_timer u_timer (
    .clock   (clock),
    .reset   (reset),
    .load_i  (timer_load),
    .delay_i (timer_delay),
    .ready_o (timer_ready)
  );

  always_ff @(posedge clock) begin
    if (reset || !ddr_cke_i) begin
      state_q <= ddl_pkg::ST_IDLE;
      cmd_q   <= ddl_pkg::CMD_NOP;
    end else begin
      if (issue) begin
        state_q <= state_d;
      end
      cmd_q <= issue ? ctl_cmd_i.cmd : ddl_pkg::CMD_NOP;
    end
  end

  // Bank and address stay on the bus between commands
  always_ff @(posedge clock) begin
    if (issue) begin
      bank_q <= ctl_cmd_i.bank;
      addr_q <= ctl_cmd_i.addr;
    end
  end

  always_comb begin
    dfi_cmd_o.ras_n = cmd_q[2];
    dfi_cmd_o.cas_n = cmd_q[1];
    dfi_cmd_o.we_n  = cmd_q[0];
    dfi_cmd_o.bank  = bank_q;
    dfi_cmd_o.addr  = addr_q;
  end

  // Column commands reach the PHY only after a row was opened
  assert property (@(posedge clock) disable iff (reset)
    (dfi_cmd_o.ras_n && !dfi_cmd_o.cas_n) |-> ($past(state_q) != ddl_pkg::ST_IDLE));

  // A refused request leaves the class, the bus and ready alone
  assert property (@(posedge clock) disable iff (reset || !ddr_cke_i)
    (accept && !legal) |=> ($stable(state_q) && cmd_q == ddl_pkg::CMD_NOP && ctl_rdy_o));

  assert property (@(posedge clock) disable iff (reset)
    (accept && ctl_cmd_i.cmd != ddl_pkg::CMD_NOP) |-> legal)
    else $warning("DDL refused %s in state %s", ctl_cmd_i.cmd.name(), state_q.name());

endmodule

`default_nettype wire

// ==== hw/ddl_wr_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddl_cfg.svh"

module ddl_wr_path (
  input  wire  clock,
  input  wire  reset,
  input  wire  wr_start_i,
  output logic dfi_wstb_o,
  output logic dfi_wren_o
);

  localparam int LEAD  = `DDL_WR_LEAD;
  localparam int BURST = `DDL_BURST_CYCLES;
  localparam int DEPTH = LEAD + BURST;
  // Cycles from the end of a clear T_CCD window to the strobe tail
  localparam int TAIL  = LEAD + BURST - `DDL_T_CCD;

  // One bit per WR issue, walking towards the PHY
  logic [DEPTH-1:0] wr_sr_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_sr_q <= '0;
    end else begin
      wr_sr_q <= {wr_sr_q[DEPTH-2:0], wr_start_i};
    end
  end

  // wr_start_i is already one cycle after the accept
  assign dfi_wstb_o = |wr_sr_q[LEAD-1 +: BURST];

  // Same window one cycle later
  assign dfi_wren_o = |wr_sr_q[LEAD +: BURST];

  // Without a follow-on WR the strobe ends after one burst
  assert property (@(posedge clock) disable iff (reset)
    (wr_start_i ##1 (!wr_start_i) [* `DDL_T_CCD]) |-> ##TAIL !dfi_wstb_o);

endmodule

`default_nettype wire

// ==== hw/ddl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddl_top (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      ddr_cke_i,

  // Controller command port
  input  wire                      ctl_req_i,
  input  wire ddl_pkg::ddl_req_t   ctl_cmd_i,
  output logic                     ctl_rdy_o,

  // Controller data ports
  input  wire ddl_pkg::ddl_wdata_t mem_wdata_i,
  output logic                     mem_wready_o,
  output logic                     mem_rvalid_o,
  output ddl_pkg::ddl_rdata_t      mem_rdata_o,

  // PHY side
  output ddl_pkg::dfi_cmd_t        dfi_cmd_o,
  output logic                     dfi_wstb_o,
  output logic                     dfi_wren_o,
  output ddl_pkg::ddl_wdata_t      dfi_wdata_o,
  input  wire                      dfi_rvld_i,
  input  wire ddl_pkg::ddl_rdata_t dfi_rdata_i
);

  logic wr_start;
  logic wr_enable;

  ddl_sequencer u_sequencer (
    .clock     (clock),
    .reset     (reset),
    .ddr_cke_i (ddr_cke_i),
    .ctl_req_i (ctl_req_i),
    .ctl_cmd_i (ctl_cmd_i),
    .ctl_rdy_o (ctl_rdy_o),
    .dfi_cmd_o (dfi_cmd_o)
  );

  // A WR on the PHY bus starts a burst
  assign wr_start = ({dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n} == ddl_pkg::CMD_WR);

  ddl_wr_path u_wr_path (
    .clock      (clock),
    .reset      (reset),
    .wr_start_i (wr_start),
    .dfi_wstb_o (dfi_wstb_o),
    .dfi_wren_o (wr_enable)
  );

  // Controller supplies write data in step with the PHY enable
  assign dfi_wren_o   = wr_enable;
  assign mem_wready_o = wr_enable;

  // Data goes straight through without buffering
  assign dfi_wdata_o  = mem_wdata_i;
  assign mem_rvalid_o = dfi_rvld_i;
  assign mem_rdata_o  = dfi_rdata_i;

endmodule

`default_nettype wire

// ==== bench/ddl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddl_cfg.svh"

module ddl_tb;

  typedef enum {STEP_CMD, STEP_CKE} step_kind_e;

  // One row of the stimulus table
  typedef struct {
    string             name;
    step_kind_e        kind;
    ddl_pkg::ddl_cmd_e cmd;
    bit                a10;
    int                delay;
    bit                issued;
  } step_t;

  logic                clock;
  logic                reset;
  logic                ddr_cke;
  logic                ctl_req;
  ddl_pkg::ddl_req_t   ctl_cmd;
  logic                ctl_rdy;
  ddl_pkg::ddl_wdata_t mem_wdata;
  logic                mem_wready;
  logic                mem_rvalid;
  ddl_pkg::ddl_rdata_t mem_rdata;
  ddl_pkg::dfi_cmd_t   dfi_cmd;
  logic                dfi_wstb;
  logic                dfi_wren;
  ddl_pkg::ddl_wdata_t dfi_wdata;
  logic                dfi_rvld;
  ddl_pkg::ddl_rdata_t dfi_rdata;

  step_t                     steps[$];
  ddl_pkg::ddl_req_t         sent [32];
  int                        marks [32];
  int                        wr_edges[$];
  logic [`DDL_BANK_BITS-1:0] last_bank;
  logic [`DDL_ROW_BITS-1:0]  last_addr;
  string                     test_name = "reset";
  int                        cycle = 0;
  int                        limit = 0;
  int                        errors = 0;
  int                        tests_run = 0;
  int                        tests_failed = 0;

  ddl_top uut (
    .clock        (clock),
    .reset        (reset),
    .ddr_cke_i    (ddr_cke),
    .ctl_req_i    (ctl_req),
    .ctl_cmd_i    (ctl_cmd),
    .ctl_rdy_o    (ctl_rdy),
    .mem_wdata_i  (mem_wdata),
    .mem_wready_o (mem_wready),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .dfi_cmd_o    (dfi_cmd),
    .dfi_wstb_o   (dfi_wstb),
    .dfi_wren_o   (dfi_wren),
    .dfi_wdata_o  (dfi_wdata),
    .dfi_rvld_i   (dfi_rvld),
    .dfi_rdata_i  (dfi_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  always @(negedge clock) begin
    if (limit > 0 && cycle >= limit) begin
      $display("Timeout: no progress after %0d cycles, the run hung", cycle);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %0h, actual %0h", what, expected, actual);
      errors++;
    end
  endtask

  // Fresh random data on both data paths every cycle
  always @(posedge clock) begin : drive_data
    logic [31:0] rnd;
    rnd = $urandom;
    mem_wdata.mask <= rnd[`DDL_MASK_BITS-1:0];
    mem_wdata.data <= $urandom;
    dfi_rdata.data <= $urandom;
    dfi_rvld       <= rnd[31];
  end

  // Strobe and enable windows follow from the recorded WR accept edges
  always @(negedge clock) begin : watch_outputs
    logic exp_stb;
    logic exp_wen;
    int   age;
    exp_stb = 1'b0;
    exp_wen = 1'b0;
    foreach (wr_edges[n]) begin
      age = cycle - wr_edges[n];
      if (age >= `DDL_WR_LEAD && age < `DDL_WR_LEAD + `DDL_BURST_CYCLES)
        exp_stb = 1'b1;
      if (age > `DDL_WR_LEAD && age <= `DDL_WR_LEAD + `DDL_BURST_CYCLES)
        exp_wen = 1'b1;
    end
    if (cycle > 0) begin
      check_value({test_name, " write strobe"}, exp_stb, dfi_wstb);
      check_value({test_name, " write enable"}, exp_wen, dfi_wren);
      check_value({test_name, " write ready"}, exp_wen, mem_wready);
      check_value({test_name, " write data"}, mem_wdata, dfi_wdata);
      check_value({test_name, " read data"}, dfi_rdata, mem_rdata);
      check_value({test_name, " read valid"}, dfi_rvld, mem_rvalid);
    end
  end

  task automatic add_step(input string name, input step_kind_e kind,
                          input ddl_pkg::ddl_cmd_e cmd, input bit a10,
                          input int delay, input bit issued);
    step_t s;
    s.name   = name;
    s.kind   = kind;
    s.cmd    = cmd;
    s.a10    = a10;
    s.delay  = delay;
    s.issued = issued;
    steps.push_back(s);
  endtask

  // Delay is the accept to accept spacing; refused steps leave ready high
  task automatic build_steps();
    add_step("mrs_0", STEP_CMD, ddl_pkg::CMD_MRS, 0, `DDL_T_MRD, 1);
    add_step("mrs_1", STEP_CMD, ddl_pkg::CMD_MRS, 0, `DDL_T_MRD, 1);
    add_step("zqcl", STEP_CMD, ddl_pkg::CMD_ZQCL, 0, `DDL_T_ZQINIT, 1);
    add_step("ref", STEP_CMD, ddl_pkg::CMD_REF, 0, `DDL_T_RFC, 1);
    // Access sequence
    add_step("act_0", STEP_CMD, ddl_pkg::CMD_ACT, 0, `DDL_T_RCD, 1);
    add_step("rd_0", STEP_CMD, ddl_pkg::CMD_RD, 0, `DDL_T_CCD, 1);
    add_step("rd_1", STEP_CMD, ddl_pkg::CMD_RD, 0, `DDL_T_CCD, 1);
    add_step("wr_0", STEP_CMD, ddl_pkg::CMD_WR, 0, `DDL_T_RTW, 1);
    add_step("rd_2", STEP_CMD, ddl_pkg::CMD_RD, 0, `DDL_T_WTR, 1);
    add_step("pre_0", STEP_CMD, ddl_pkg::CMD_PRE, 0, `DDL_T_RP, 1);
    // Back to back bursts, auto-precharge and refusals
    add_step("act_1", STEP_CMD, ddl_pkg::CMD_ACT, 0, `DDL_T_RCD, 1);
    add_step("wr_1", STEP_CMD, ddl_pkg::CMD_WR, 0, `DDL_T_CCD, 1);
    add_step("wr_2", STEP_CMD, ddl_pkg::CMD_WR, 0, `DDL_T_CCD, 1);
    add_step("wr_ap", STEP_CMD, ddl_pkg::CMD_WR, 1, `DDL_T_WRA, 1);
    add_step("rd_refused", STEP_CMD, ddl_pkg::CMD_RD, 0, 1, 0);
    add_step("act_2", STEP_CMD, ddl_pkg::CMD_ACT, 0, `DDL_T_RCD, 1);
    add_step("nop", STEP_CMD, ddl_pkg::CMD_NOP, 0, 1, 0);
    // Clock-enable drop puts the state back to IDLE
    add_step("rd_3", STEP_CMD, ddl_pkg::CMD_RD, 0, `DDL_T_CCD, 1);
    add_step("cke_low", STEP_CKE, ddl_pkg::CMD_NOP, 0, `DDL_T_XPR, 1);
    add_step("rd_idle", STEP_CMD, ddl_pkg::CMD_RD, 0, 1, 0);
    add_step("act_3", STEP_CMD, ddl_pkg::CMD_ACT, 0, `DDL_T_RCD, 1);
  endtask

  task automatic report_step(input string name, input int mark, input int gap);
    tests_run++;
    if (errors == mark) begin
      $display("%-12s passed, gap %0d", name, gap);
    end else begin
      tests_failed++;
      $display("%-12s failed", name);
    end
  endtask

  // Called just after a negedge; the bus must idle while ready is low
  task automatic count_to_ready(input string name, output int edges);
    edges = 0;
    while (!ctl_rdy) begin
      @(posedge clock);
      @(negedge clock);
      edges++;
      check_value({name, " nop"}, 3'b111, {dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n});
    end
  endtask

  task automatic check_reset();
    int mark;
    int gap;
    mark = errors;
    repeat (3) begin
      @(negedge clock);
      check_value("reset ready", 1'b0, ctl_rdy);
      check_value("reset nop", 3'b111, {dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n});
    end
    @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    count_to_ready("reset", gap);
    check_value("reset gap", `DDL_T_XPR, gap);
    report_step("reset", mark, gap);
  endtask

  // Entered just after the negedge that follows the accept edge
  task automatic finish_step(input int p);
    ddl_pkg::dfi_cmd_t exp_bus;
    logic [2:0]        code;
    int                edges;
    code = steps[p].issued ? steps[p].cmd : 3'b111;
    if (steps[p].issued) begin
      last_bank = sent[p].bank;
      last_addr = sent[p].addr;
      if (steps[p].cmd == ddl_pkg::CMD_WR)
        wr_edges.push_back(cycle);
    end
    exp_bus.ras_n = code[2];
    exp_bus.cas_n = code[1];
    exp_bus.we_n  = code[0];
    exp_bus.bank  = last_bank;
    exp_bus.addr  = last_addr;
    check_value({steps[p].name, " bus"}, exp_bus, dfi_cmd);
    count_to_ready(steps[p].name, edges);
    check_value({steps[p].name, " gap"}, steps[p].delay, edges + 1);
    report_step(steps[p].name, marks[p], edges + 1);
  endtask

  task automatic cycle_cke(input int i);
    int edges;
    marks[i] = errors;
    @(posedge clock);
    test_name = steps[i].name;
    ddr_cke <= 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_value({steps[i].name, " ready"}, 1'b0, ctl_rdy);
      check_value({steps[i].name, " nop"}, 3'b111,
                  {dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n});
    end
    @(posedge clock);
    ddr_cke <= 1'b1;
    @(negedge clock);
    count_to_ready(steps[i].name, edges);
    check_value({steps[i].name, " gap"}, steps[i].delay, edges);
    report_step(steps[i].name, marks[i], edges);
  endtask

  initial begin : main
    ddl_pkg::ddl_req_t req_v;
    logic [31:0]       rnd;
    int                pend;
    int                total;
    void'($urandom(49086));
    reset     = 1'b1;
    ddr_cke   = 1'b1;
    ctl_req   = 1'b0;
    ctl_cmd   = '0;
    mem_wdata = '0;
    dfi_rvld  = 1'b0;
    dfi_rdata = '0;
    build_steps();
    // Reset, both init waits, a burst tail, a few edges per step and a margin
    total = 4 + 2 * `DDL_T_XPR + `DDL_WR_LEAD + `DDL_BURST_CYCLES + 100;
    foreach (steps[n])
      total += steps[n].delay + 4;
    limit = total;
    check_reset();
    pend = -1;
    for (int i = 0; i < steps.size(); i++) begin
      if (steps[i].kind == STEP_CKE) begin
        if (pend >= 0) begin
          ctl_req <= 1'b0;
          @(negedge clock);
          finish_step(pend);
          pend = -1;
        end
        cycle_cke(i);
      end else begin
        if (pend < 0)
          @(posedge clock);
        rnd            = $urandom;
        req_v.cmd      = steps[i].cmd;
        req_v.bank     = rnd[`DDL_BANK_BITS-1:0];
        req_v.addr     = rnd[`DDL_BANK_BITS +: `DDL_ROW_BITS];
        req_v.addr[10] = steps[i].a10;
        sent[i]        = req_v;
        marks[i]       = errors;
        ctl_req <= 1'b1;
        ctl_cmd <= req_v;
        @(negedge clock);
        if (pend >= 0)
          finish_step(pend);
        // Ready is high here, so this edge takes the request
        @(posedge clock);
        pend = i;
        test_name = steps[i].name;
      end
    end
    if (pend >= 0) begin
      ctl_req <= 1'b0;
      @(negedge clock);
      finish_step(pend);
    end
    repeat (`DDL_WR_LEAD + `DDL_BURST_CYCLES + 2) @(negedge clock);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/ddl_pkg.sv
hw/sequencer/ddl_timer.sv
hw/sequencer/ddl_sequencer.sv
hw/ddl_wr_path.sv
hw/ddl_top.sv
bench/ddl_tb.sv

// ==== Bender.yml ====
package:
  name: ddl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ddl_pkg.sv
      - hw/sequencer/ddl_timer.sv
      - hw/sequencer/ddl_sequencer.sv
      - hw/ddl_wr_path.sv
      - hw/ddl_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/ddl_tb.sv
